/* logic/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    localparam int tlb_entries = 16;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;    // vaddr[31:13], one even/odd page pair
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [3:0]  tlb_idx_t;
    typedef logic [2:0]  cattr_t;

    // one 4k page of an entry
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;    // dirty, i.e. writable
        logic   v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;       // ignore asid on match
        tlb_page_t even;    // vaddr[12] == 0
        tlb_page_t odd;
    } tlb_entry_t;

    typedef struct packed {
        logic   req;
        vaddr_t vaddr;
    } xlat_req_t;

    // registered lookup result, fields zero on a miss
    typedef struct packed {
        logic     valid;
        logic     found;
        tlb_idx_t index;
        paddr_t   paddr;
        cattr_t   c;
        logic     d;
        logic     v;
    } xlat_rsp_t;

endpackage

`default_nettype wire

/* logic/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    typedef logic [4:0] cp0_sel_t;

    // register numbers for mtc0/mfc0
    localparam cp0_sel_t cp0_sel_index    = 5'd0;
    localparam cp0_sel_t cp0_sel_entrylo0 = 5'd2;
    localparam cp0_sel_t cp0_sel_entrylo1 = 5'd3;
    localparam cp0_sel_t cp0_sel_entryhi  = 5'd10;

    // index
    localparam int index_p_bit   = 31;  // probe failed
    localparam int index_idx_lsb = 0;

    // entrylo0 / entrylo1 share one layout
    localparam int lo_pfn_lsb = 6;
    localparam int lo_c_lsb   = 3;
    localparam int lo_d_bit   = 2;
    localparam int lo_v_bit   = 1;
    localparam int lo_g_bit   = 0;

    // entryhi
    localparam int hi_vpn2_lsb = 13;
    localparam int hi_asid_lsb = 0;

endpackage

`default_nettype wire

/* logic/tlb_cp0_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_cp0_ctrl
    import mmu_pkg::*;
    import cp0_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        cp0_wr,
    input  cp0_sel_t    cp0_wsel,
    input  logic [31:0] cp0_wdata,
    input  cp0_sel_t    cp0_rsel,
    output logic [31:0] cp0_rdata,
    input  logic        tlbwi,
    input  logic        tlbp,
    output asid_t       cur_asid,
    output logic        entry_wr,
    output tlb_idx_t    entry_wr_idx,
    output tlb_entry_t  entry_wdata,
    output xlat_req_t   probe_req,
    input  xlat_rsp_t   probe_rsp
);

    logic      index_p;
    tlb_idx_t  index_q;
    vpn2_t     hi_vpn2;
    asid_t     hi_asid;
    tlb_page_t lo0_page;
    tlb_page_t lo1_page;
    logic      lo0_g;
    logic      lo1_g;
    tlb_page_t wr_page;     // entrylo fields of the write data

    function automatic logic [31:0] lo_word(tlb_page_t p, logic g);
        logic [31:0] w;
        w = '0;
        w[lo_pfn_lsb +: $bits(pfn_t)] = p.pfn;
        w[lo_c_lsb +: $bits(cattr_t)] = p.c;
        w[lo_d_bit]                   = p.d;
        w[lo_v_bit]                   = p.v;
        w[lo_g_bit]                   = g;
        return w;
    endfunction

    assign wr_page = '{pfn: cp0_wdata[lo_pfn_lsb +: $bits(pfn_t)],
                       c:   cp0_wdata[lo_c_lsb +: $bits(cattr_t)],
                       d:   cp0_wdata[lo_d_bit],
                       v:   cp0_wdata[lo_v_bit]};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            index_p  <= 1'b0;
            index_q  <= '0;
            hi_vpn2  <= '0;
            hi_asid  <= '0;
            lo0_page <= '0;
            lo1_page <= '0;
            lo0_g    <= 1'b0;
            lo1_g    <= 1'b0;
        end else begin
            if (cp0_wr) begin
                case (cp0_wsel)
                    cp0_sel_entrylo0: begin
                        lo0_page <= wr_page;
                        lo0_g    <= cp0_wdata[lo_g_bit];
                    end
                    cp0_sel_entrylo1: begin
                        lo1_page <= wr_page;
                        lo1_g    <= cp0_wdata[lo_g_bit];
                    end
                    cp0_sel_entryhi: begin
                        hi_vpn2 <= cp0_wdata[hi_vpn2_lsb +: $bits(vpn2_t)];
                        hi_asid <= cp0_wdata[hi_asid_lsb +: $bits(asid_t)];
                    end
                    default: ;
                endcase
            end
            // probe result has priority over an index write in the same cycle
            if (probe_rsp.valid) begin
                index_p <= !probe_rsp.found;
                if (probe_rsp.found) begin
                    index_q <= probe_rsp.index;
                end
            end else if (cp0_wr && cp0_wsel == cp0_sel_index) begin
                index_p <= 1'b0;    // only a probe sets p
                index_q <= cp0_wdata[index_idx_lsb +: $bits(tlb_idx_t)];
            end
        end
    end

    always_comb begin
        cp0_rdata = '0;
        case (cp0_rsel)
            cp0_sel_index: begin
                cp0_rdata[index_p_bit]                       = index_p;
                cp0_rdata[index_idx_lsb +: $bits(tlb_idx_t)] = index_q;
            end
            cp0_sel_entrylo0: cp0_rdata = lo_word(lo0_page, lo0_g);
            cp0_sel_entrylo1: cp0_rdata = lo_word(lo1_page, lo1_g);
            cp0_sel_entryhi: begin
                cp0_rdata[hi_vpn2_lsb +: $bits(vpn2_t)] = hi_vpn2;
                cp0_rdata[hi_asid_lsb +: $bits(asid_t)] = hi_asid;
            end
            default: ;
        endcase
    end

    assign cur_asid = hi_asid;

    // tlbwi, entry built from this cycle's registers
    assign entry_wr     = tlbwi;
    assign entry_wr_idx = index_q;
    assign entry_wdata  = '{vpn2: hi_vpn2, asid: hi_asid, g: lo0_g & lo1_g,
                            even: lo0_page, odd: lo1_page};

    // tlbp searches the even page of the entryhi pair
    assign probe_req = '{req: tlbp, vaddr: {hi_vpn2, 13'd0}};

    a_tlb_op_excl : assert property (@(posedge aclk) disable iff (!arst_n)
        !(tlbwi && tlbp));

endmodule

`default_nettype wire

/* logic/tlb_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array
    import mmu_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,
    input  logic       entry_wr,
    input  tlb_idx_t   entry_wr_idx,
    input  tlb_entry_t entry_wdata,
    output tlb_entry_t entries [tlb_entries]
);

    logic [tlb_entries-1:0] wr_sel;    // one-hot write enable

    always_comb begin
        wr_sel               = '0;
        wr_sel[entry_wr_idx] = entry_wr;
    end

    for (genvar i = 0; i < tlb_entries; i++) begin : g_entry
        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                entries[i] <= '0;   // vpn2 0 with v clear
            end else if (wr_sel[i]) begin
                entries[i] <= entry_wdata;
            end
        end
    end

    // an unknown index would corrupt an arbitrary entry
    a_wr_idx_known : assert property (@(posedge aclk) disable iff (!arst_n)
        entry_wr |-> !$isunknown(entry_wr_idx));

endmodule

`default_nettype wire

/* logic/tlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup
    import mmu_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,
    input  xlat_req_t  req,
    input  asid_t      asid,
    input  tlb_entry_t entries [tlb_entries],
    output xlat_rsp_t  rsp
);

    vpn2_t                  req_vpn2;
    logic                   odd_sel;
    logic [tlb_entries-1:0] match;
    logic                   hit;
    tlb_idx_t               hit_idx;
    tlb_page_t              page;
    xlat_rsp_t              rsp_d;

    assign req_vpn2 = req.vaddr[31:13];
    assign odd_sel  = req.vaddr[12];

    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match[i] = (entries[i].vpn2 == req_vpn2) &&
                       (entries[i].g || entries[i].asid == asid);
        end
    end

    // scan down so the lowest matching index is the last one kept
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit     = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign page = odd_sel ? entries[hit_idx].odd : entries[hit_idx].even;

    always_comb begin
        rsp_d       = '0;
        rsp_d.valid = req.req;
        if (hit) begin
            rsp_d.found = 1'b1;
            rsp_d.index = hit_idx;
            rsp_d.paddr = {page.pfn, req.vaddr[11:0]};  // 4k page offset
            rsp_d.c     = page.c;
            rsp_d.d     = page.d;
            rsp_d.v     = page.v;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp <= rsp_d;
        end
    end

    // an unknown address on a live request poisons the translation
    a_req_addr_known : assert property (@(posedge aclk) disable iff (!arst_n)
        req.req |-> !$isunknown(req.vaddr));

endmodule

`default_nettype wire

/* logic/tlb_mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu_top
    import mmu_pkg::*;
    import cp0_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        cp0_wr,
    input  cp0_sel_t    cp0_wsel,
    input  logic [31:0] cp0_wdata,
    input  cp0_sel_t    cp0_rsel,
    output logic [31:0] cp0_rdata,
    input  logic        tlbwi,
    input  logic        tlbp,
    input  xlat_req_t   fetch_req,
    input  xlat_req_t   data_req,
    output xlat_rsp_t   fetch_rsp,
    output xlat_rsp_t   data_rsp
);

    asid_t      cur_asid;
    logic       entry_wr;
    tlb_idx_t   entry_wr_idx;
    tlb_entry_t entry_wdata;
    tlb_entry_t entries [tlb_entries];
    xlat_req_t  probe_req;
    xlat_rsp_t  probe_rsp;

    tlb_cp0_ctrl ctrl_i (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .cp0_wr       (cp0_wr),
        .cp0_wsel     (cp0_wsel),
        .cp0_wdata    (cp0_wdata),
        .cp0_rsel     (cp0_rsel),
        .cp0_rdata    (cp0_rdata),
        .tlbwi        (tlbwi),
        .tlbp         (tlbp),
        .cur_asid     (cur_asid),
        .entry_wr     (entry_wr),
        .entry_wr_idx (entry_wr_idx),
        .entry_wdata  (entry_wdata),
        .probe_req    (probe_req),
        .probe_rsp    (probe_rsp)
    );

    tlb_entry_array array_i (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .entry_wr     (entry_wr),
        .entry_wr_idx (entry_wr_idx),
        .entry_wdata  (entry_wdata),
        .entries      (entries)
    );

    // instruction fetch port
    tlb_lookup fetch_lookup_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .req     (fetch_req),
        .asid    (cur_asid),
        .entries (entries),
        .rsp     (fetch_rsp)
    );

    tlb_lookup data_lookup_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .req     (data_req),
        .asid    (cur_asid),
        .entries (entries),
        .rsp     (data_rsp)
    );

    tlb_lookup probe_lookup_i (     // tlbp search
        .aclk    (aclk),
        .arst_n  (arst_n),
        .req     (probe_req),
        .asid    (cur_asid),
        .entries (entries),
        .rsp     (probe_rsp)
    );

endmodule

`default_nettype wire

/* dv/tlb_mmu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_mmu_tb
    import mmu_pkg::*;
    import cp0_pkg::*;
();

    localparam int period   = 10;
    localparam int n_cycles = 4000;

    logic        aclk;
    logic        arst_n;
    logic        cp0_wr;
    cp0_sel_t    cp0_wsel;
    logic [31:0] cp0_wdata;
    cp0_sel_t    cp0_rsel;
    logic [31:0] cp0_rdata;
    logic        tlbwi;
    logic        tlbp;
    xlat_req_t   fetch_req;
    xlat_req_t   data_req;
    xlat_rsp_t   fetch_rsp;
    xlat_rsp_t   data_rsp;

    // reference model state
    logic [31:0] m_hi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic        m_p;
    tlb_idx_t    m_idx;
    tlb_entry_t  m_ent [tlb_entries];
    logic        probe_due;     // tlbp result lands at the next edge
    xlat_rsp_t   probe_hold;
    xlat_rsp_t   exp_fetch [$];
    xlat_rsp_t   exp_data [$];
    logic [31:0] seed = 32'hd13a96a0;
    int          hits;

    tlb_mmu_top dut_i (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cp0_wr    (cp0_wr),
        .cp0_wsel  (cp0_wsel),
        .cp0_wdata (cp0_wdata),
        .cp0_rsel  (cp0_rsel),
        .cp0_rdata (cp0_rdata),
        .tlbwi     (tlbwi),
        .tlbp      (tlbp),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever #(period / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // entrylo word -> page: pfn 25:6, c 5:3, d 2, v 1
    function automatic tlb_page_t page_from_lo(logic [31:0] w);
        tlb_page_t p;
        p.pfn = w[25:6];
        p.c   = w[5:3];
        p.d   = w[2];
        p.v   = w[1];
        return p;
    endfunction

    function automatic tlb_entry_t entry_from_regs();
        tlb_entry_t e;
        e.vpn2 = m_hi[31:13];
        e.asid = m_hi[7:0];
        e.g    = m_lo0[0] & m_lo1[0];  // global only if both pages say so
        e.even = page_from_lo(m_lo0);
        e.odd  = page_from_lo(m_lo1);
        return e;
    endfunction

    function automatic xlat_rsp_t expected_xlat(xlat_req_t q, asid_t asid);
        xlat_rsp_t r;
        tlb_page_t pg;
        r       = '0;
        r.valid = q.req;
        for (int i = 0; i < tlb_entries; i++) begin
            if (!r.found && m_ent[i].vpn2 == q.vaddr[31:13] &&
                    (m_ent[i].g || m_ent[i].asid == asid)) begin
                pg      = q.vaddr[12] ? m_ent[i].odd : m_ent[i].even;
                r.found = 1'b1;
                r.index = tlb_idx_t'(i);
                r.paddr = {pg.pfn, q.vaddr[11:0]};
                r.c     = pg.c;
                r.d     = pg.d;
                r.v     = pg.v;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] expected_rdata(cp0_sel_t sel);
        case (sel)
            cp0_sel_index:    return {m_p, 27'd0, m_idx};
            cp0_sel_entrylo0: return m_lo0;
            cp0_sel_entrylo1: return m_lo1;
            cp0_sel_entryhi:  return m_hi;
            default:          return '0;
        endcase
    endfunction

    // fields behind an idle response are don't care
    function automatic xlat_rsp_t rsp_visible(xlat_rsp_t r);
        return r.valid ? r : '0;
    endfunction

    function automatic vaddr_t pick_vaddr();
        logic [31:0] v;
        v = next_rand();
        case (v[1:0])
            2'd0:    return v;                              // mostly misses
            2'd1:    return {16'h2a5c, v[15:0]};            // shared vpn2 pool
            default: return {m_ent[v[5:2]].vpn2, v[12:0]};  // a stored entry
        endcase
    endfunction

    task automatic check_outputs();
        xlat_rsp_t ef;
        xlat_rsp_t ed;
        ef = exp_fetch.pop_front();
        ed = exp_data.pop_front();
        if (ef.valid && ef.found) hits++;
        check_value("fetch_rsp", 64'(rsp_visible(ef)), 64'(rsp_visible(fetch_rsp)));
        check_value("data_rsp", 64'(rsp_visible(ed)), 64'(rsp_visible(data_rsp)));
        check_value("cp0_rdata", 64'(expected_rdata(cp0_rsel)), 64'(cp0_rdata));
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] wd;
        cp0_sel_t    ws;
        xlat_req_t   pq;
        xlat_rsp_t   probe_now;
        r  = next_rand();
        wd = next_rand();
        case (r[3:2])
            2'd0:    ws = cp0_sel_index;
            2'd1:    ws = cp0_sel_entrylo0;
            2'd2:    ws = cp0_sel_entrylo1;
            default: ws = cp0_sel_entryhi;
        endcase
        if (ws == cp0_sel_entryhi) begin
            wd[7:2] = '0;                                // four asids only
            if (r[5:4] != 2'd0) wd[31:16] = 16'h2a5c;    // eight vpn2 values
        end
        cp0_wr          = r[0];
        cp0_wsel        = ws;
        cp0_wdata       = wd;
        cp0_rsel        = r[6] ? r[11:7] : ws;
        tlbwi           = (r[14:13] == 2'd0);
        tlbp            = (r[14:12] == 3'd2);
        fetch_req.req   = r[15] | r[16];
        fetch_req.vaddr = pick_vaddr();
        data_req.req    = r[17] | r[18];
        data_req.vaddr  = pick_vaddr();

        // results use the state in front of the coming edge
        exp_fetch.push_back(expected_xlat(fetch_req, m_hi[7:0]));
        exp_data.push_back(expected_xlat(data_req, m_hi[7:0]));
        pq.req    = 1'b1;
        pq.vaddr  = {m_hi[31:13], 13'd0};
        probe_now = expected_xlat(pq, m_hi[7:0]);

        if (tlbwi) m_ent[m_idx] = entry_from_regs();
        if (cp0_wr) begin
            case (ws)
                cp0_sel_index: begin
                    if (!probe_due) begin    // probe result wins
                        m_p   = 1'b0;
                        m_idx = wd[3:0];
                    end
                end
                cp0_sel_entrylo0: m_lo0 = wd & 32'h03ff_ffff;
                cp0_sel_entrylo1: m_lo1 = wd & 32'h03ff_ffff;
                default:          m_hi  = wd & 32'hffff_e0ff;
            endcase
        end
        if (probe_due) begin
            m_p = !probe_hold.found;
            if (probe_hold.found) m_idx = probe_hold.index;
        end
        probe_due  = tlbp;
        probe_hold = probe_now;
    endtask

    initial begin
        arst_n     = 1'b0;
        cp0_wr     = 1'b0;
        cp0_wsel   = '0;
        cp0_wdata  = '0;
        cp0_rsel   = '0;
        tlbwi      = 1'b0;
        tlbp       = 1'b0;
        fetch_req  = '0;
        data_req   = '0;
        m_hi       = '0;
        m_lo0      = '0;
        m_lo1      = '0;
        m_p        = 1'b0;
        m_idx      = '0;
        probe_due  = 1'b0;
        probe_hold = '0;
        hits       = 0;
        for (int i = 0; i < tlb_entries; i++) m_ent[i] = '0;
        repeat (2) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        drive_cycle();
        for (int n = 0; n < n_cycles; n++) begin
            @(posedge aclk);
            #1;
            check_outputs();
            drive_cycle();
        end
        if (hits == 0) begin
            $display("no lookup ever hit a TLB entry, stimulus is broken");
            $display("tests failed");
            $fatal(1, "no hits");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    initial begin
        #((n_cycles + 2 + 20) * period);
        $display("watchdog expired before the test loop finished");
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

/* tb.f */
logic/mmu_pkg.sv
logic/cp0_pkg.sv
logic/tlb_cp0_ctrl.sv
logic/tlb_entry_array.sv
logic/tlb_lookup.sv
logic/tlb_mmu_top.sv
dv/tlb_mmu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tlb_mmu_tb -f tb.f -o tlb_mmu_sim

./obj_dir/tlb_mmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
